//--- compile.f
+incdir+.
rv_pkg.sv
rv_decoder.sv
rv_regfile.sv
rv_lsu.sv
rv_core_top.sv
rv_checker.sv
tb_rv_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal -j 0
LINTFLAGS ?= --lint-only --timing --assert --timescale 1ns/1ps -Wall
PASS_MSG  ?= ** PASS **

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$($(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_cfg.svh"

module tb_rv_core;

  localparam int mem_words = 4096;
  localparam int hold_cycles = 3; // cycles watched after halt
  localparam logic [31:0] ebreak_word = 32'h0010_0073;

  logic                  clk;
  logic                  rst_n;
  logic [`RV_XLEN-1:0]   imem_addr;
  logic [`RV_XLEN-1:0]   imem_rdata;
  logic [`RV_XLEN-1:0]   dmem_addr;
  logic [`RV_XLEN-1:0]   dmem_rdata;
  logic [`RV_XLEN-1:0]   dmem_wdata;
  logic                  dmem_wen;
  logic                  halt;
  logic [`RV_MASK_W-1:0] dmem_wmask;
  int                    err_count;

  logic [`RV_XLEN-1:0] mem [mem_words]; // code at 0x8000_0000, data at 0x400
  logic [31:0]         prog [$];
  int                  cycles = 0;
  int                  limit = 0;
  int                  tests = 0;
  int                  failed = 0;

  always #20 clk = ~clk;

  assign imem_rdata = mem[imem_addr[13:2]];
  assign dmem_rdata = mem[dmem_addr[13:2]];

  always @(posedge clk) begin
    if (dmem_wen) begin
      for (int b = 0; b < `RV_MASK_W; b++) begin
        if (dmem_wmask[b]) begin
          mem[dmem_addr[13:2]][8*b +: 8] <= dmem_wdata[8*b +: 8];
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > limit) begin
      $display("timeout: core never halted within %0d cycles", limit);
      $display("** FAIL **");
      $finish;
    end
  end

  rv_core_top u_rv_core_top (
    .clk        (clk),
    .rst_n      (rst_n),
    .imem_rdata (imem_rdata),
    .dmem_rdata (dmem_rdata),
    .imem_addr  (imem_addr),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_wen   (dmem_wen),
    .halt       (halt),
    .dmem_wmask (dmem_wmask)
  );

  rv_checker u_checker (
    .clk        (clk),
    .rst_n      (rst_n),
    .imem_addr  (imem_addr),
    .imem_rdata (imem_rdata),
    .dmem_addr  (dmem_addr),
    .dmem_rdata (dmem_rdata),
    .dmem_wdata (dmem_wdata),
    .dmem_wen   (dmem_wen),
    .dmem_wmask (dmem_wmask),
    .halt       (halt),
    .err_count  (err_count)
  );

  function automatic logic [31:0] itype(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] stype(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b010_0011};
  endfunction

  function automatic logic [31:0] utype(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] jtype(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b110_1111};
  endfunction

  // sw rs2 into result slot, x0 based
  task automatic save_reg(input logic [4:0] rs2, input int slot);
    prog.push_back(stype(12'(32'h400 + 4 * slot), rs2, 5'd0, rv_pkg::MEM_W));
  endtask

  task automatic arith_program();
    logic [4:0] rd;
    logic [4:0] written [$];
    for (int i = 0; i < 12; i++) begin
      rd = 5'($urandom_range(31, 1));
      case ($urandom_range(2))
        0: prog.push_back(itype(12'($urandom), 5'($urandom), 3'b000, rd, rv_pkg::OP_IMM));
        1: prog.push_back(utype(20'($urandom), rd, rv_pkg::LUI));
        default: prog.push_back(utype(20'($urandom), rd, rv_pkg::AUIPC));
      endcase
      written.push_back(rd);
    end
    foreach (written[i]) save_reg(written[i], i);
  endtask

  task automatic jump_program();
    int         k;
    logic [4:0] rd;
    logic [4:0] links [$];
    for (int r = 0; r < 6; r++) begin
      k = $urandom_range(3);
      rd = 5'($urandom_range(31, 6));
      prog.push_back(jtype(21'(4 * (k + 1)), rd));
      repeat (k) prog.push_back(ebreak_word); // skipped words
      links.push_back(rd);
      k = $urandom_range(3);
      rd = 5'($urandom_range(31, 6));
      prog.push_back(utype(20'h0_0000, 5'd5, rv_pkg::AUIPC));
      // odd offsets exercise the cleared bit 0
      prog.push_back(itype(12'(8 + 4 * k + $urandom_range(1)), 5'd5, 3'b000, rd,
                           rv_pkg::JALR));
      repeat (k) prog.push_back(ebreak_word);
      links.push_back(rd);
    end
    foreach (links[i]) save_reg(links[i], i);
  endtask

  task automatic store_program();
    logic [2:0] size;
    int         off;
    for (int r = 1; r <= 8; r++) begin
      prog.push_back(utype(20'($urandom), 5'(r), rv_pkg::LUI));
      prog.push_back(itype(12'($urandom), 5'(r), 3'b000, 5'(r), rv_pkg::OP_IMM));
    end
    for (int i = 0; i < 16; i++) begin
      size = 3'($urandom_range(2));
      off = 32'h400 + 4 * $urandom_range(127);
      if (size == 3'd0) off += $urandom_range(3);
      if (size == 3'd1) off += 2 * $urandom_range(1);
      prog.push_back(stype(12'(off), 5'($urandom_range(8, 1)), 5'd0, size));
    end
  endtask

  task automatic loadback_program();
    logic [2:0] f3;
    logic [4:0] rd;
    int         off;
    for (int i = 'h180; i < 'h200; i++) mem[i] = $urandom; // words at 0x600
    for (int i = 0; i < 16; i++) begin
      f3 = 3'($urandom_range(4));
      if (f3 > 3'd2) f3 += 3'd1; // 3 and 4 become bu and hu
      rd = 5'($urandom_range(31, 1));
      off = 32'h600 + 4 * $urandom_range(127);
      if (f3[1:0] == 2'd0) off += $urandom_range(3);
      if (f3[1:0] == 2'd1) off += 2 * $urandom_range(1);
      prog.push_back(itype(12'(off), 5'd0, f3, rd, rv_pkg::LOAD));
      save_reg(rd, i);
    end
  endtask

  task automatic run_test(input string name, input int kind);
    int errs_before;
    prog.delete();
    case (kind)
      1: arith_program();
      2: jump_program();
      3: store_program();
      4: loadback_program();
      5: begin
        prog.push_back(ebreak_word); // fetched while reset is still low
        save_reg(5'd1, 0); // past the halt
      end
      default: begin
        save_reg(5'd0, 2); // a store sits at the reset pc
        prog.push_back(itype(12'h123, 5'd0, 3'b000, 5'd1, rv_pkg::OP_IMM));
        save_reg(5'd1, 0);
      end
    endcase
    prog.push_back(ebreak_word);
    limit += 2 * (prog.size() + 3);
    errs_before = err_count;
    @(posedge clk);
    rst_n <= 1'b0;
    foreach (prog[i]) mem[i] <= prog[i];
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    do @(negedge clk); while (!halt);
    repeat (hold_cycles) @(negedge clk);
    tests++;
    if (err_count == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      failed++;
      $display("test %s: %0d mismatches", name, err_count - errs_before);
    end
  endtask

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    void'($urandom(32'he793));
    for (int i = 0; i < mem_words; i++) begin
      mem[i] = (32'(i) * 32'h9e37_79b9) ^ 32'h5a5a_0000;
    end
    run_test("reset", 0);
    run_test("arith", 1);
    run_test("jumps", 2);
    run_test("stores", 3);
    run_test("loads", 4);
    run_test("halt", 5);
    $display("tests %0d, failed %0d, errors %0d", tests, failed, err_count);
    if (failed == 0 && err_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- rv_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_cfg.svh"

module rv_checker (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [`RV_XLEN-1:0]   imem_addr,
  input  logic [`RV_XLEN-1:0]   imem_rdata,
  input  logic [`RV_XLEN-1:0]   dmem_addr,
  input  logic [`RV_XLEN-1:0]   dmem_rdata,
  input  logic [`RV_XLEN-1:0]   dmem_wdata,
  input  logic                  dmem_wen,
  input  logic [`RV_MASK_W-1:0] dmem_wmask,
  input  logic                  halt,
  output int                    err_count
);

  logic [31:0] regs [`RV_NUM_REGS]; // architectural state of the model
  logic [31:0] exp_pc;
  int          errors = 0;

  assign err_count = errors;

  // one instruction of the subset, straight from the RV32I encodings
  function automatic void predict(
    input  logic [31:0] instr,
    input  logic [31:0] pc,
    input  logic [31:0] x [`RV_NUM_REGS],
    input  logic [31:0] mem_word,
    output logic [31:0] next_pc,
    output logic        wr,
    output logic [31:0] wr_val,
    output logic        acc,
    output logic        st,
    output logic [31:0] addr,
    output logic [3:0]  mask,
    output logic [31:0] data,
    output logic        stop
  );
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] lane;
    a = x[instr[19:15]];
    b = x[instr[24:20]];
    imm_i = {{20{instr[31]}}, instr[31:20]};
    next_pc = pc + 32'd4;
    wr = 1'b0;
    wr_val = '0;
    acc = 1'b0;
    st = 1'b0;
    addr = '0;
    mask = '0;
    data = '0;
    stop = 1'b0;
    case (instr[6:0])
      rv_pkg::OP_IMM: begin
        wr = (instr[14:12] == 3'b000);
        wr_val = a + imm_i;
      end
      rv_pkg::LUI: begin
        wr = 1'b1;
        wr_val = {instr[31:12], 12'h000};
      end
      rv_pkg::AUIPC: begin
        wr = 1'b1;
        wr_val = pc + {instr[31:12], 12'h000};
      end
      rv_pkg::JAL: begin
        wr = 1'b1;
        wr_val = pc + 32'd4;
        next_pc = pc + {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      rv_pkg::JALR: begin
        wr = 1'b1;
        wr_val = pc + 32'd4;
        next_pc = (a + imm_i) & ~32'd1;
      end
      rv_pkg::LOAD: begin
        acc = 1'b1;
        wr = 1'b1;
        addr = a + imm_i;
        lane = mem_word >> {addr[1:0], 3'b000};
        case (instr[14:12])
          rv_pkg::MEM_B:  wr_val = {{24{lane[7]}}, lane[7:0]};
          rv_pkg::MEM_H:  wr_val = {{16{lane[15]}}, lane[15:0]};
          rv_pkg::MEM_W:  wr_val = lane;
          rv_pkg::MEM_BU: wr_val = {24'h00_0000, lane[7:0]};
          rv_pkg::MEM_HU: wr_val = {16'h0000, lane[15:0]};
          default:        wr_val = '0;
        endcase
      end
      rv_pkg::STORE: begin
        acc = 1'b1;
        st = 1'b1;
        addr = a + {{20{instr[31]}}, instr[31:25], instr[11:7]};
        case (instr[14:12])
          rv_pkg::MEM_B: begin
            mask = 4'b0001 << addr[1:0];
            data = {4{b[7:0]}}; // every lane, only the masked one counts
          end
          rv_pkg::MEM_H: begin
            mask = 4'b0011 << addr[1:0];
            data = {2{b[15:0]}};
          end
          default: begin
            mask = 4'b1111;
            data = b;
          end
        endcase
      end
      rv_pkg::SYSTEM: begin
        if (instr == 32'h0010_0073) begin
          stop = 1'b1;
          next_pc = pc; // ebreak parks the core
        end
      end
      default: ;
    endcase
  endfunction

  task automatic check(input string field, input logic [31:0] exp, input logic [31:0] got);
    if (got !== exp) begin
      $display("Fail %0t: %s expected %h, got %h", $time, field, exp, got);
      errors++;
    end
  endtask

  // outputs settle between edges, so compare on the falling edge
  always @(negedge clk) begin : compare
    logic [31:0] e_next;
    logic        e_wr;
    logic [31:0] e_val;
    logic        e_acc;
    logic        e_st;
    logic [31:0] e_addr;
    logic [3:0]  e_mask;
    logic [31:0] e_data;
    logic        e_stop;
    logic [31:0] lanes;
    if (!rst_n) begin
      exp_pc = `RV_RESET_PC;
      foreach (regs[i]) regs[i] = '0;
      check("dmem_wen", 32'd0, 32'(dmem_wen)); // nothing commits in reset
      check("halt", 32'd0, 32'(halt));
      check("imem_addr", exp_pc, imem_addr);
    end else begin
      check("imem_addr", exp_pc, imem_addr);
      predict(imem_rdata, exp_pc, regs, dmem_rdata, e_next, e_wr, e_val, e_acc, e_st,
              e_addr, e_mask, e_data, e_stop);
      check("halt", 32'(e_stop), 32'(halt));
      check("dmem_wen", 32'(e_st), 32'(dmem_wen));
      if (e_acc) check("dmem_addr", e_addr, dmem_addr);
      if (e_st) begin
        check("dmem_wmask", 32'(e_mask), 32'(dmem_wmask));
        for (int i = 0; i < 4; i++) lanes[8*i +: 8] = {8{e_mask[i]}};
        check("dmem_wdata", e_data & lanes, dmem_wdata & lanes);
      end
      exp_pc = e_next;
      if (e_wr && imem_rdata[11:7] != 5'd0) regs[imem_rdata[11:7]] = e_val;
    end
  end

endmodule

`default_nettype wire

//--- rv_core_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_cfg.svh"

module rv_core_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [`RV_XLEN-1:0]   imem_rdata,
  input  logic [`RV_XLEN-1:0]   dmem_rdata,
  output logic [`RV_XLEN-1:0]   imem_addr,
  output logic [`RV_XLEN-1:0]   dmem_addr,
  output logic [`RV_XLEN-1:0]   dmem_wdata,
  output logic                  dmem_wen,
  output logic                  halt,
  output logic [`RV_MASK_W-1:0] dmem_wmask
);

  logic [`RV_XLEN-1:0]   pc;
  logic [`RV_XLEN-1:0]   pc_plus4;
  logic [`RV_XLEN-1:0]   pc_next;
  logic [`RV_XLEN-1:0]   opa;
  logic [`RV_XLEN-1:0]   sum;      // data address, jump target, alu result
  logic [`RV_XLEN-1:0]   wb_data;
  logic [`RV_XLEN-1:0]   imm;
  logic [`RV_XLEN-1:0]   rs1_data;
  logic [`RV_XLEN-1:0]   rs2_data;
  logic [`RV_XLEN-1:0]   load_data;
  logic [`RV_REG_AW-1:0] rs1_addr;
  logic [`RV_REG_AW-1:0] rs2_addr;
  logic [`RV_REG_AW-1:0] rd_addr;
  logic                  reg_wen;
  logic                  rf_wen;
  logic                  mem_read;
  logic                  mem_write;
  logic                  is_ebreak;
  rv_pkg::opa_sel_e      opa_sel;
  rv_pkg::wb_sel_e       wb_sel;
  rv_pkg::mem_size_e     mem_size;

  rv_decoder u_decoder (
    .instr     (imem_rdata),
    .rs1_addr  (rs1_addr),
    .rs2_addr  (rs2_addr),
    .rd_addr   (rd_addr),
    .reg_wen   (reg_wen),
    .mem_read  (mem_read),
    .mem_write (mem_write),
    .is_ebreak (is_ebreak),
    .opa_sel   (opa_sel),
    .wb_sel    (wb_sel),
    .mem_size  (mem_size),
    .imm       (imm)
  );

  rv_regfile u_regfile (
    .clk    (clk),
    .rst_n  (rst_n),
    .wen    (rf_wen),
    .waddr  (rd_addr),
    .raddr1 (rs1_addr),
    .raddr2 (rs2_addr),
    .wdata  (wb_data),
    .rdata1 (rs1_data),
    .rdata2 (rs2_data)
  );

  rv_lsu u_lsu (
    .clk        (clk),
    .rst_n      (rst_n),
    .mem_read   (mem_read),
    .mem_write  (mem_write),
    .mem_size   (mem_size),
    .byte_off   (sum[1:0]),
    .store_data (rs2_data),
    .dmem_rdata (dmem_rdata),
    .wmask      (dmem_wmask),
    .wdata      (dmem_wdata),
    .load_data  (load_data)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= `RV_RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

  always_comb begin
    case (opa_sel)
      rv_pkg::OPA_PC:   opa = pc;
      rv_pkg::OPA_ZERO: opa = '0;
      default:          opa = rs1_data;
    endcase
  end

  assign sum      = opa + imm;
  assign pc_plus4 = pc + 32'd4;

  // held in reset or on ebreak, nothing is committed
  assign halt     = is_ebreak && rst_n;
  assign rf_wen   = reg_wen && rst_n && !halt;
  assign dmem_wen = mem_write && rst_n && !halt;

  // only jumps link, so the link select also picks the jump target
  always_comb begin
    if (halt) begin
      pc_next = pc;
    end else if (wb_sel == rv_pkg::WB_PC4) begin
      pc_next = {sum[`RV_XLEN-1:1], 1'b0}; // jalr clears bit 0
    end else begin
      pc_next = pc_plus4;
    end
  end

  always_comb begin
    case (wb_sel)
      rv_pkg::WB_PC4:  wb_data = pc_plus4;
      rv_pkg::WB_LOAD: wb_data = load_data;
      default:         wb_data = sum;
    endcase
  end

  assign imem_addr = pc;
  assign dmem_addr = sum; // byte address, memory aligns the word

endmodule

`default_nettype wire

//--- rv_lsu.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_cfg.svh"

module rv_lsu (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  mem_read,
  input  logic                  mem_write,
  input  rv_pkg::mem_size_e     mem_size,
  input  logic [1:0]            byte_off,
  input  logic [`RV_XLEN-1:0]   store_data,
  input  logic [`RV_XLEN-1:0]   dmem_rdata,
  output logic [`RV_MASK_W-1:0] wmask,
  output logic [`RV_XLEN-1:0]   wdata,
  output logic [`RV_XLEN-1:0]   load_data
);

  logic [4:0]          lane_shift; // byte offset in bits
  logic [`RV_XLEN-1:0] lane;       // addressed lane moved down to bit 0

  assign lane_shift = {byte_off, 3'b000};
  assign lane       = dmem_rdata >> lane_shift;

  // store side, unused lanes carry zero
  always_comb begin
    wmask = '0;
    wdata = '0;
    if (mem_write) begin
      case (mem_size)
        rv_pkg::MEM_B: begin
          wmask = 4'b0001 << byte_off;
          wdata = {24'h00_0000, store_data[7:0]} << lane_shift;
        end
        rv_pkg::MEM_H: begin
          wmask = 4'b0011 << byte_off;
          wdata = {16'h0000, store_data[15:0]} << lane_shift;
        end
        rv_pkg::MEM_W: begin
          wmask = 4'b1111;
          wdata = store_data;
        end
        default: ; // no unsigned stores
      endcase
    end
  end

  // load side
  always_comb begin
    load_data = '0;
    if (mem_read) begin
      case (mem_size)
        rv_pkg::MEM_B:  load_data = {{24{lane[7]}}, lane[7:0]};
        rv_pkg::MEM_H:  load_data = {{16{lane[15]}}, lane[15:0]};
        rv_pkg::MEM_W:  load_data = lane;
        rv_pkg::MEM_BU: load_data = {24'h00_0000, lane[7:0]};
        rv_pkg::MEM_HU: load_data = {16'h0000, lane[15:0]};
        default:        load_data = '0;
      endcase
    end
  end

  a_half_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    ((mem_read || mem_write) &&
     (mem_size == rv_pkg::MEM_H || mem_size == rv_pkg::MEM_HU)) |-> !byte_off[0])
    else $error("lsu: misaligned half-word access, offset %0d", byte_off);

  a_word_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    ((mem_read || mem_write) && (mem_size == rv_pkg::MEM_W)) |-> (byte_off == 2'b00))
    else $error("lsu: misaligned word access, offset %0d", byte_off);

endmodule

`default_nettype wire

//--- rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_cfg.svh"

module rv_regfile (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wen,
  input  logic [`RV_REG_AW-1:0] waddr,
  input  logic [`RV_REG_AW-1:0] raddr1,
  input  logic [`RV_REG_AW-1:0] raddr2,
  input  logic [`RV_XLEN-1:0]   wdata,
  output logic [`RV_XLEN-1:0]   rdata1,
  output logic [`RV_XLEN-1:0]   rdata2
);

  logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (waddr != '0)) begin // x0 stays zero
      regs[waddr] <= wdata;
    end
  end

  // reads see the value before this cycle's write
  assign rdata1 = regs[raddr1];
  assign rdata2 = regs[raddr2];

endmodule

`default_nettype wire

//--- rv_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_cfg.svh"

module rv_decoder (
  input  logic [31:0]            instr,
  output logic [`RV_REG_AW-1:0]  rs1_addr,
  output logic [`RV_REG_AW-1:0]  rs2_addr,
  output logic [`RV_REG_AW-1:0]  rd_addr,
  output logic                   reg_wen,
  output logic                   mem_read,
  output logic                   mem_write,
  output logic                   is_ebreak,
  output rv_pkg::opa_sel_e       opa_sel,
  output rv_pkg::wb_sel_e        wb_sel,
  output rv_pkg::mem_size_e      mem_size,
  output logic [`RV_XLEN-1:0]    imm
);

  rv_pkg::opcode_e     opcode;
  logic [2:0]          funct3;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_s;
  logic [`RV_XLEN-1:0] imm_u;
  logic [`RV_XLEN-1:0] imm_j;

  assign opcode   = rv_pkg::opcode_e'(instr[6:0]);
  assign funct3   = instr[14:12];
  assign rd_addr  = instr[11:7];
  assign rs1_addr = instr[19:15];
  assign rs2_addr = instr[24:20];
  assign mem_size = rv_pkg::mem_size_e'(funct3);

  // immediate formats, all sign-extended from bit 31
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_u = {instr[31:12], 12'h000}; // already shifted
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  // only the exact ebreak encoding halts
  assign is_ebreak = (instr == 32'h0010_0073);

  always_comb begin
    reg_wen   = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    opa_sel   = rv_pkg::OPA_RS1;
    wb_sel    = rv_pkg::WB_ALU;
    imm       = imm_i;
    case (opcode)
      rv_pkg::OP_IMM: begin
        reg_wen = (funct3 == 3'b000); // addi only
      end
      rv_pkg::LUI: begin
        reg_wen = 1'b1;
        opa_sel = rv_pkg::OPA_ZERO;
        imm     = imm_u;
      end
      rv_pkg::AUIPC: begin
        reg_wen = 1'b1;
        opa_sel = rv_pkg::OPA_PC;
        imm     = imm_u;
      end
      rv_pkg::JAL: begin
        reg_wen = 1'b1;
        opa_sel = rv_pkg::OPA_PC;
        wb_sel  = rv_pkg::WB_PC4;
        imm     = imm_j;
      end
      rv_pkg::JALR: begin
        reg_wen = 1'b1;
        wb_sel  = rv_pkg::WB_PC4; // target is rs1 + imm_i
      end
      rv_pkg::LOAD: begin
        reg_wen  = 1'b1;
        mem_read = 1'b1;
        wb_sel   = rv_pkg::WB_LOAD;
      end
      rv_pkg::STORE: begin
        mem_write = 1'b1;
        imm       = imm_s;
      end
      default: ; // system and unknown opcodes have no side effects
    endcase
  end

endmodule

`default_nettype wire

//--- rv_pkg.sv
`default_nettype none

package rv_pkg;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    OP_IMM = 7'b001_0011,
    LUI    = 7'b011_0111,
    AUIPC  = 7'b001_0111,
    JAL    = 7'b110_1111,
    JALR   = 7'b110_0111,
    LOAD   = 7'b000_0011,
    STORE  = 7'b010_0011,
    SYSTEM = 7'b111_0011
  } opcode_e;

  // register write-back source
  typedef enum logic [1:0] {
    WB_ALU  = 2'd0, // adder result
    WB_PC4  = 2'd1, // link address
    WB_LOAD = 2'd2  // extended load data
  } wb_sel_e;

  // first adder operand, second is always the immediate
  typedef enum logic [1:0] {
    OPA_RS1  = 2'd0,
    OPA_PC   = 2'd1,
    OPA_ZERO = 2'd2 // lui passes the immediate through
  } opa_sel_e;

  // funct3 of loads and stores
  typedef enum logic [2:0] {
    MEM_B  = 3'b000,
    MEM_H  = 3'b001,
    MEM_W  = 3'b010,
    MEM_BU = 3'b100, // loads only
    MEM_HU = 3'b101  // loads only
  } mem_size_e;

endpackage

`default_nettype wire

//--- rv_cfg.svh
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// datapath and address width
`define RV_XLEN 32

// first fetch after reset
`define RV_RESET_PC 32'h8000_0000

// architectural register file
`define RV_NUM_REGS 32
`define RV_REG_AW 5

// one strobe bit per byte lane of a data word
`define RV_MASK_W 4

`endif
